// ==== rtl/core_pkg.sv ====
package core_pkg;

  // datapath widths
  localparam int audio_in_w = 15;  // raw mixer output
  localparam int audio_w    = 16;  // after sign extension
  localparam int joy_w      = 6;   // fire2 fire right left down up
  localparam int ram_aw     = 22;  // word address 22 down to 1

  // first byte of a settings message
  localparam logic [7:0] cmd_set_cfg = 8'h01;

  // register ids in the second byte
  localparam logic [7:0] reg_chipset    = 8'd0;
  localparam logic [7:0] reg_memory     = 8'd1;
  localparam logic [7:0] reg_video      = 8'd2;
  localparam logic [7:0] reg_reset      = 8'd3;  // bit 0 reset, bit 1 coldboot
  localparam logic [7:0] reg_volume     = 8'd4;
  localparam logic [7:0] reg_port_mouse = 8'd5;
  localparam logic [7:0] reg_tos_slot   = 8'd6;

  localparam logic [1:0] vol_full = 2'd3;  // volume after reset

  // port_mouse codes
  localparam logic [1:0] mouse_hid   = 2'd0;
  localparam logic [1:0] mouse_atari = 2'd1;
  localparam logic [1:0] mouse_amiga = 2'd2;
  localparam logic [1:0] mouse_off   = 2'd3;

  // chipset codes
  localparam logic [1:0] chip_st   = 2'd0;
  localparam logic [1:0] chip_mega = 2'd1;  // adds blitter
  localparam logic [1:0] chip_ste  = 2'd2;  // blitter and ste

endpackage

// ==== rtl/cfg_if.sv ====
`timescale 1ns/1ps

// decoded system settings from the register block
interface cfg_if;

  logic [1:0] chipset;     // st / mega / ste
  logic       extra_ram;   // memory setting
  logic       mono;        // high for mono monitor
  logic       reset_req;   // holds the machine in reset
  logic       coldboot;    // rising edge scrambles ram
  logic [1:0] volume;      // 0 mute .. 3 full
  logic [1:0] port_mouse;  // source of the mouse port
  logic       tos_slot;    // secondary tos image

  modport src (
    output chipset, extra_ram, mono, reset_req, coldboot, volume, port_mouse, tos_slot
  );

  modport sink (
    input chipset, extra_ram, mono, reset_req, coldboot, volume, port_mouse, tos_slot
  );

endinterface

// ==== rtl/sys_config.sv ====
`timescale 1ns/1ps

module sys_config (
  input  logic       clk_32,
  input  logic       rst_n,
  input  logic       mcu_strobe,  // one byte per strobe
  input  logic       mcu_start,   // first byte of a message
  input  logic [7:0] mcu_data,
  cfg_if.src         cfg,
  output logic       ste,
  output logic       blitter_en
);

  logic [1:0] byte_cnt;  // 0 ignore, 1 id next, 2 value next
  logic [7:0] reg_id;    // id of the pending write
  logic       wr_en;

  // settings registers
  logic [1:0] chipset_q;
  logic       memory_q;
  logic       video_q;
  logic [1:0] reset_q;
  logic [1:0] volume_q;
  logic [1:0] port_mouse_q;
  logic       tos_slot_q;

  // a start byte always restarts the message position
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      byte_cnt <= 2'd0;
    end else if (mcu_strobe) begin
      if (mcu_start) begin
        byte_cnt <= (mcu_data == core_pkg::cmd_set_cfg) ? 2'd1 : 2'd0;  // other cmds dropped
      end else begin
        byte_cnt <= (byte_cnt == 2'd1) ? 2'd2 : 2'd0;  // done after value byte
      end
    end
  end

  always_ff @(posedge clk_32) begin
    if (mcu_strobe && !mcu_start && byte_cnt == 2'd1) begin
      reg_id <= mcu_data;  // second byte
    end
  end

  assign wr_en = mcu_strobe && !mcu_start && (byte_cnt == 2'd2);

  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      chipset_q    <= core_pkg::chip_st;
      memory_q     <= 1'b0;
      video_q      <= 1'b0;
      reset_q      <= 2'b00;
      volume_q     <= core_pkg::vol_full;  // start at full volume
      port_mouse_q <= core_pkg::mouse_hid;
      tos_slot_q   <= 1'b0;
    end else if (wr_en) begin
      case (reg_id)
        core_pkg::reg_chipset:    chipset_q    <= mcu_data[1:0];
        core_pkg::reg_memory:     memory_q     <= mcu_data[0];
        core_pkg::reg_video:      video_q      <= mcu_data[0];
        core_pkg::reg_reset:      reset_q      <= mcu_data[1:0];
        core_pkg::reg_volume:     volume_q     <= mcu_data[1:0];
        core_pkg::reg_port_mouse: port_mouse_q <= mcu_data[1:0];
        core_pkg::reg_tos_slot:   tos_slot_q   <= mcu_data[0];
        default: ;  // unknown id writes nothing
      endcase
    end
  end

  assign cfg.chipset    = chipset_q;
  assign cfg.extra_ram  = memory_q;
  assign cfg.mono       = ~video_q;  // video 0 selects mono
  assign cfg.reset_req  = reset_q[0];
  assign cfg.coldboot   = reset_q[1];
  assign cfg.volume     = volume_q;
  assign cfg.port_mouse = port_mouse_q;
  assign cfg.tos_slot   = tos_slot_q;

  // machine flags from chipset code
  assign blitter_en = (chipset_q == core_pkg::chip_mega) || (chipset_q == core_pkg::chip_ste);
  assign ste        = (chipset_q == core_pkg::chip_ste);

endmodule

// ==== rtl/port_mapper.sv ====
`timescale 1ns/1ps

module port_mapper (
  cfg_if.sink                         cfg,
  input  logic [7:0]                  io,         // active low db9 pins
  input  logic [core_pkg::joy_w-1:0]  hid_mouse,  // usb mouse
  input  logic [7:0]                  hid_joy,    // usb joystick
  output logic [core_pkg::joy_w-1:0]  joy0,       // mouse port
  output logic [4:0]                  joy1        // joystick port
);

  logic [core_pkg::joy_w-1:0] db9_atari;
  logic [core_pkg::joy_w-1:0] db9_amiga;
  logic [4:0]                 db9_joy;

  // two wiring orders of the same db9 pins
  assign db9_atari = ~{io[5], io[0], io[2], io[1], io[4], io[3]};
  assign db9_amiga = ~{io[5], io[0], io[3], io[1], io[4], io[2]};  // h/v pulses swapped

  // a db9 mouse replaces the usb one
  // mice hold lines active, so no wired or here
  always_comb begin
    case (cfg.port_mouse)
      core_pkg::mouse_hid:   joy0 = hid_mouse;
      core_pkg::mouse_atari: joy0 = db9_atari;
      core_pkg::mouse_amiga: joy0 = db9_amiga;
      default:               joy0 = '0;  // mouse_off
    endcase
  end

  // db9 doubles as joystick only while mouse is on usb
  assign db9_joy = (cfg.port_mouse == core_pkg::mouse_hid) ? db9_atari[4:0] : 5'd0;

  assign joy1 = hid_joy[4:0] | db9_joy;  // both usable in parallel

endmodule

// ==== rtl/audio_volume.sv ====
`timescale 1ns/1ps

module audio_volume (
  input  logic                                  clk_32,
  input  logic                                  rst_n,
  cfg_if.sink                                   cfg,
  input  logic signed [core_pkg::audio_in_w-1:0] audio_in_l,
  input  logic signed [core_pkg::audio_in_w-1:0] audio_in_r,
  output logic        [core_pkg::audio_w-1:0]    audio_l,
  output logic        [core_pkg::audio_w-1:0]    audio_r
);

  // widen by one bit, then divide by 1, 2 or 4
  function automatic logic [core_pkg::audio_w-1:0] atten(
    input logic signed [core_pkg::audio_in_w-1:0] s,
    input logic [1:0]                              vol
  );
    logic signed [core_pkg::audio_w-1:0] ext;
    ext = {s[core_pkg::audio_in_w-1], s};  // sign extension
    case (vol)
      2'd0:    return '0;        // mute
      2'd1:    return ext >>> 2; // quarter rounded down
      2'd2:    return ext >>> 1; // half
      default: return ext;       // vol_full
    endcase
  endfunction

  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= atten(audio_in_l, cfg.volume);
      audio_r <= atten(audio_in_r, cfg.volume);
    end
  end

endmodule

// ==== rtl/boot_ctrl.sv ====
`timescale 1ns/1ps

module boot_ctrl #(
  parameter int unsigned BOOT_WAIT_CYCLES = 64_000_000  // 2 s at 32 MHz
) (
  input  logic                         clk_32,
  input  logic                         rst_n,
  cfg_if.sink                          cfg,
  input  logic                         ram_ready,     // sdram init done
  input  logic                         flash_ready,   // rom reader up
  input  logic                         button_reset,  // high active user button
  input  logic [31:0]                  img_size,      // non-zero once image is open
  input  logic [core_pkg::ram_aw:1]    ram_addr_in,
  output logic                         core_resb,
  output logic [core_pkg::ram_aw:1]    ram_addr_out
);

  logic [31:0] wait_cnt;
  logic        sd_ready;
  logic        cb_d;      // coldboot delayed
  logic [1:0]  scramble;

  // give the mcu time to mount a default image
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= 32'd0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size != 32'd0) begin
        sd_ready <= 1'b1;  // card and image present
      end
      if (wait_cnt < BOOT_WAIT_CYCLES) begin
        wait_cnt <= wait_cnt + 32'd1;
      end else begin
        sd_ready <= 1'b1;  // boot without image after the timeout
      end
    end
  end

  // machine runs only when everything is up
  assign core_resb = sd_ready && ram_ready && flash_ready &&
                     !button_reset && !cfg.reset_req;

  // coldboot rising edge invalidates ram contents
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      cb_d     <= 1'b0;
      scramble <= 2'd0;
    end else begin
      cb_d <= cfg.coldboot;
      if (cfg.coldboot && !cb_d) begin
        scramble <= scramble + 2'd1;  // next pattern
      end
    end
  end

  // xor word address bits 4 and 3 and pass the rest straight through
  assign ram_addr_out = {ram_addr_in[core_pkg::ram_aw:5],
                         ram_addr_in[4:3] ^ scramble,
                         ram_addr_in[2:1]};

endmodule

// ==== rtl/core_glue.sv ====
`timescale 1ns/1ps

module core_glue #(
  parameter int unsigned BOOT_WAIT_CYCLES = 64_000_000
) (
  input  logic                                   clk_32,
  input  logic                                   rst_n,
  // settings byte stream from the mcu
  input  logic                                   mcu_strobe,
  input  logic                                   mcu_start,
  input  logic [7:0]                             mcu_data,
  output logic                                   ste,
  output logic                                   blitter_en,
  // mouse and joystick
  input  logic [7:0]                             io,
  input  logic [core_pkg::joy_w-1:0]             hid_mouse,
  input  logic [7:0]                             hid_joy,
  output logic [core_pkg::joy_w-1:0]             joy0,
  output logic [4:0]                             joy1,
  // audio
  input  logic signed [core_pkg::audio_in_w-1:0] audio_in_l,
  input  logic signed [core_pkg::audio_in_w-1:0] audio_in_r,
  output logic [core_pkg::audio_w-1:0]           audio_l,
  output logic [core_pkg::audio_w-1:0]           audio_r,
  // boot and ram
  input  logic                                   ram_ready,
  input  logic                                   flash_ready,
  input  logic                                   button_reset,
  input  logic [31:0]                            img_size,
  input  logic [core_pkg::ram_aw:1]              ram_addr_in,
  output logic                                   core_resb,
  output logic [core_pkg::ram_aw:1]              ram_addr_out
);

  cfg_if cfg ();  // settings bus

  sys_config u_sys_config (
    .clk_32     (clk_32),
    .rst_n      (rst_n),
    .mcu_strobe (mcu_strobe),
    .mcu_start  (mcu_start),
    .mcu_data   (mcu_data),
    .cfg        (cfg.src),
    .ste        (ste),
    .blitter_en (blitter_en)
  );

  port_mapper u_port_mapper (
    .cfg       (cfg.sink),
    .io        (io),
    .hid_mouse (hid_mouse),
    .hid_joy   (hid_joy),
    .joy0      (joy0),
    .joy1      (joy1)
  );

  audio_volume u_audio_volume (
    .clk_32     (clk_32),
    .rst_n      (rst_n),
    .cfg        (cfg.sink),
    .audio_in_l (audio_in_l),
    .audio_in_r (audio_in_r),
    .audio_l    (audio_l),
    .audio_r    (audio_r)
  );

  boot_ctrl #(
    .BOOT_WAIT_CYCLES (BOOT_WAIT_CYCLES)
  ) u_boot_ctrl (
    .clk_32       (clk_32),
    .rst_n        (rst_n),
    .cfg          (cfg.sink),
    .ram_ready    (ram_ready),
    .flash_ready  (flash_ready),
    .button_reset (button_reset),
    .img_size     (img_size),
    .ram_addr_in  (ram_addr_in),
    .core_resb    (core_resb),
    .ram_addr_out (ram_addr_out)
  );

endmodule

// ==== tb/glue_checker.sv ====
`timescale 1ns/1ps

module glue_checker (
  input logic                         ste,
  input logic                         blitter_en,
  input logic [core_pkg::joy_w-1:0]   joy0,
  input logic [4:0]                   joy1,
  input logic [core_pkg::audio_w-1:0] audio_l,
  input logic [core_pkg::audio_w-1:0] audio_r,
  input logic                         core_resb,
  input logic [core_pkg::ram_aw:1]    ram_addr_out
);

  int errors = 0;        // all failures of the run
  int tests = 0;
  int failed_tests = 0;
  int test_errors = 0;   // failures in the running test

  // a failure that is not a wrong value
  task automatic fail(input string msg);
    $display("Failure at time %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  // compare one DUT port, picked by name, with its expected value
  task automatic check(input string name, input logic [31:0] want);
    logic [31:0] got;
    case (name)
      "ste":          got = 32'(ste);
      "blitter_en":   got = 32'(blitter_en);
      "joy0":         got = 32'(joy0);
      "joy1":         got = 32'(joy1);
      "audio_l":      got = 32'(audio_l);
      "audio_r":      got = 32'(audio_r);
      "core_resb":    got = 32'(core_resb);
      "ram_addr_out": got = 32'(ram_addr_out);
      default: begin
        fail($sformatf("the DUT has no port named %s to compare", name));
        return;
      end
    endcase
    if (got !== want) begin
      $display("Error at time %0t: %s is %0h, expected %0h", $time, name, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("test %0d, %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d, %s: %0d errors", tests, name, test_errors);
    end
    test_errors = 0;  // next test starts clean
  endtask

  task automatic summary();
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests,
             tests - failed_tests, failed_tests, errors);
  endtask

endmodule

// ==== tb/tb_core_glue.sv ====
`timescale 1ns/1ps

module tb_core_glue;

  localparam int unsigned boot_wait = 300;  // short sd image timeout

  logic                                   clk_32;
  logic                                   rst_n;
  logic                                   mcu_strobe;
  logic                                   mcu_start;
  logic [7:0]                             mcu_data;
  logic [7:0]                             io;
  logic [core_pkg::joy_w-1:0]             hid_mouse;
  logic [7:0]                             hid_joy;
  logic signed [core_pkg::audio_in_w-1:0] audio_in_l;
  logic signed [core_pkg::audio_in_w-1:0] audio_in_r;
  logic                                   ram_ready;
  logic                                   flash_ready;
  logic                                   button_reset;
  logic [31:0]                            img_size;
  logic [core_pkg::ram_aw:1]              ram_addr_in;
  logic                                   ste;
  logic                                   blitter_en;
  logic [core_pkg::joy_w-1:0]             joy0;
  logic [4:0]                             joy1;
  logic [core_pkg::audio_w-1:0]           audio_l;
  logic [core_pkg::audio_w-1:0]           audio_r;
  logic                                   core_resb;
  logic [core_pkg::ram_aw:1]              ram_addr_out;
  logic [31:0]                            lfsr;  // random state

  core_glue #(.BOOT_WAIT_CYCLES(boot_wait)) UUT (.*);

  glue_checker chk (.*);

  initial begin
    clk_32 = 1'b0;
    forever #20 clk_32 = ~clk_32;  // 40 ns period
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);  // one step per bit
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // sign extend then take 0, x/4, x/2 or x rounded down
  function automatic logic [15:0] scaled(input logic [14:0] s, input logic [1:0] vol);
    int v;
    int d;
    int q;
    v = int'($signed(s));
    if (vol == 2'd0) return 16'd0;
    d = (vol == 2'd1) ? 4 : (vol == 2'd2) ? 2 : 1;
    q = v / d;
    if (v < 0 && (v % d) != 0) q = q - 1;  // toward minus infinity
    return 16'(q);
  endfunction

  task automatic apply_reset();
    int i;
    rst_n = 1'b0;
    for (i = 0; i < 16; i++) @(negedge clk_32);
    rst_n = 1'b1;
  endtask

  task automatic send_byte(input logic start, input logic [7:0] data);
    mcu_strobe = 1'b1;
    mcu_start  = start;
    mcu_data   = data;
    @(negedge clk_32);
    mcu_strobe = 1'b0;
    mcu_start  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] id, input logic [7:0] val);
    send_byte(1'b1, core_pkg::cmd_set_cfg);
    send_byte(1'b0, id);
    send_byte(1'b0, val);  // setting live from here
  endtask

  task automatic run_audio(input logic [1:0] vol, input int n);
    logic [31:0] l;
    logic [31:0] r;
    int i;
    for (i = 0; i < n; i++) begin
      take_bits(15, l);
      take_bits(15, r);
      audio_in_l = l[14:0];
      audio_in_r = r[14:0];
      @(negedge clk_32);  // one register stage
      chk.check("audio_l", 32'(scaled(l[14:0], vol)));
      chk.check("audio_r", 32'(scaled(r[14:0], vol)));
    end
  endtask

  task automatic coldboot_steps(input int n);
    logic [31:0]               addr;
    logic [core_pkg::ram_aw:1] want;
    int i;
    for (i = 1; i <= n; i++) begin
      write_reg(core_pkg::reg_reset, 8'h02);  // coldboot rises
      write_reg(core_pkg::reg_reset, 8'h00);
      take_bits(core_pkg::ram_aw, addr);
      ram_addr_in = addr[core_pkg::ram_aw-1:0];
      want = addr[core_pkg::ram_aw-1:0];
      want[4:3] = want[4:3] ^ i[1:0];  // pattern 1 2 3 0
      @(negedge clk_32);
      chk.check("ram_addr_out", 32'(want));
    end
  endtask

  initial begin
    string       line;
    byte         op;
    logic [31:0] a, b, c, d, e, f;
    int          fd;
    int          cnt;
    int          lineno;
    rst_n = 1'b0;
    mcu_strobe = 1'b0;
    mcu_start = 1'b0;
    mcu_data = 8'd0;
    io = 8'hff;  // db9 idle high
    hid_mouse = '0;
    hid_joy = 8'd0;
    audio_in_l = '0;
    audio_in_r = '0;
    ram_ready = 1'b1;
    flash_ready = 1'b1;
    button_reset = 1'b0;
    img_size = 32'd0;
    ram_addr_in = '0;
    lfsr = 32'hc056_ce8f;
    lineno = 0;
    @(negedge clk_32);
    fd = $fopen("tb/glue_cases.txt", "r");
    if (fd == 0) begin
      chk.fail("the test file tb/glue_cases.txt could not be opened");
    end else begin
      while ($fgets(line, fd) != 0) begin
        lineno++;
        op = line.getc(0);
        if (line.len() == 0 || op == "#" || op == "\n") continue;
        {a, b, c, d, e, f} = '0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                      a, b, c, d, e, f));
        case (op)
          "R": begin
            img_size = 32'd0;
            audio_in_l = 15'h2d4b;  // non-zero samples while in reset
            audio_in_r = 15'h52b4;
            apply_reset();
            chk.check("core_resb", 32'd0);
            chk.check("audio_l", 32'd0);
            chk.check("audio_r", 32'd0);
          end
          "S": begin
            chk.check("core_resb", 32'd0);
            img_size = a;
            @(negedge clk_32);
            chk.check("core_resb", 32'd1);
          end
          "A": run_audio(a[1:0], int'(b));
          "V": begin
            write_reg(core_pkg::reg_volume, a[7:0]);
            run_audio(a[1:0], int'(b));
          end
          "I": begin
            send_byte(1'b1, core_pkg::cmd_set_cfg);
            send_byte(1'b0, core_pkg::reg_volume);
            send_byte(1'b1, 8'h00);  // new start with another command
            send_byte(1'b0, a[7:0]);
            run_audio(b[1:0], int'(c));
          end
          "H": begin
            write_reg(core_pkg::reg_chipset, a[7:0]);
            chk.check("ste", b);
            chk.check("blitter_en", c);
          end
          "P": begin
            write_reg(core_pkg::reg_port_mouse, a[7:0]);
            io = b[7:0];
            hid_mouse = c[core_pkg::joy_w-1:0];
            hid_joy = d[7:0];
            @(negedge clk_32);
            chk.check("joy0", e);
            chk.check("joy1", f);
          end
          "T": begin
            img_size = 32'd0;
            apply_reset();
            chk.check("core_resb", 32'd0);
            cnt = 0;
            while (!core_resb && cnt < boot_wait + 2) begin
              @(negedge clk_32);
              cnt++;
            end
            if (!core_resb) begin
              chk.fail($sformatf("core_resb stayed low for %0d cycles after reset", cnt));
            end
          end
          "Q": begin
            chk.check("core_resb", 32'd1);
            write_reg(core_pkg::reg_reset, 8'h01);  // reset_req
            chk.check("core_resb", 32'd0);
          end
          "X": coldboot_steps(int'(a));
          default: chk.fail($sformatf("line %0d has an unknown operation", lineno));
        endcase
        chk.end_test($sformatf("line %0d op %c", lineno, op));
      end
      $fclose(fd);
    end
    chk.summary();
    if (chk.errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb/glue_cases.txt ====
# op then hex fields: R reset, S img_size, A/V vol count, I value vol count, H chip ste blit
# P mode io hid_mouse hid_joy joy0 joy1, T boot timeout, Q reset_req, X coldboot count
R
S 00001000
A 3 10
V 0 8
V 1 10
V 2 10
I 0 2 8
H 0 0 0
H 1 0 1
H 2 1 1
P 0 e6 2a c4 2a 17
P 1 5a 15 0b 38 0b
P 2 5a 15 f3 31 13
P 3 00 3f 1f 00 1f
T
Q
X 4

// ==== vlog.f ====
rtl/core_pkg.sv
rtl/cfg_if.sv
rtl/sys_config.sv
rtl/port_mapper.sv
rtl/audio_volume.sv
rtl/boot_ctrl.sv
rtl/core_glue.sv
tb/glue_checker.sv
tb/tb_core_glue.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_core_glue
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
